//--- files.f
common/job_ctrl_pkg.sv
job_ctrl/context_sequencer.sv
job_ctrl/job_counters.sv
job_ctrl/context_regs.sv
job_ctrl/job_ctrl_top.sv
tests/tb_clock_gen.sv
tests/tb_job_ctrl.sv

//--- Bender.yml
package:
  name: job_ctrl

sources:
  - common/job_ctrl_pkg.sv
  - job_ctrl/context_sequencer.sv
  - job_ctrl/job_counters.sv
  - job_ctrl/context_regs.sv
  - job_ctrl/job_ctrl_top.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/tb_job_ctrl.sv

//--- tests/tb_job_ctrl.sv
// Testbench for the job offload controller
// Runs acquire, trigger, queued engine jobs and counter reads against a reference model
`timescale 1ns/1ns

module tb_job_ctrl;
  import job_ctrl_pkg::*;

  localparam int unsigned N_OPS           = 40;  // Bus operations and engine waits
  localparam int unsigned WATCHDOG_CYCLES = N_OPS * 20;
  localparam int unsigned START_TIMEOUT   = 10;

  logic                                clk, rst_n;
  logic                                req, we, done;
  logic [ADDR_W-1:0]                   addr;
  logic [DATA_W-1:0]                   wdata, rdata;
  logic                                rvalid, start;
  logic [CTX_W-1:0]                    run_ctx;
  logic [N_PARAM_REGS-1:0][DATA_W-1:0] params;

  // Reference model state
  logic [N_CONTEXTS-1:0][N_PARAM_REGS-1:0][DATA_W-1:0] param_model;
  logic [N_CONTEXTS-1:0] busy_model;
  logic                  locked_model;
  logic [CTX_W-1:0]      ptr_model;
  logic [CTX_W-1:0]      exp_run_ctx;  // Context the engine must start next
  int unsigned           offload_model, finished_model, running_model;
  logic [DATA_W-1:0]     exp_rdata;
  string                 test_name;
  integer                seed;

  tb_clock_gen #(.PERIOD_NS(40), .RESET_CYCLES(8)) i_clock_gen (.clk_o(clk), .rst_no(rst_n));

  job_ctrl_top dut (
    .clk_i     ( clk     ),
    .rst_ni    ( rst_n   ),
    .req_i     ( req     ),
    .we_i      ( we      ),
    .addr_i    ( addr    ),
    .wdata_i   ( wdata   ),
    .done_i    ( done    ),
    .rdata_o   ( rdata   ),
    .rvalid_o  ( rvalid  ),
    .start_o   ( start   ),
    .run_ctx_o ( run_ctx ),
    .params_o  ( params  )
  );

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1, "stopping after the first error");
  endtask

  task automatic report_mismatch(input string name,
                                 input logic [N_PARAM_REGS*DATA_W-1:0] exp_val,
                                 input logic [N_PARAM_REGS*DATA_W-1:0] act_val);
    abort_run($sformatf("ERROR %s: expected 0x%0h, actual 0x%0h", name, exp_val, act_val));
  endtask

  assert property (@(posedge clk) disable iff (!rst_n) (req && !we) |=> rvalid)
    else abort_run("read response missing one cycle after a read request");

  assert property (@(posedge clk) disable iff (!rst_n) (req && !we) |=> rdata == exp_rdata)
    else report_mismatch(test_name, exp_rdata, $sampled(rdata));

  assert property (@(posedge clk) disable iff (!rst_n) start |-> run_ctx == exp_run_ctx)
    else report_mismatch("engine start context", exp_run_ctx, $sampled(run_ctx));

  assert property (@(posedge clk) disable iff (!rst_n)
    start |-> params == param_model[exp_run_ctx])
    else report_mismatch("engine start parameters", param_model[exp_run_ctx], $sampled(params));

  function automatic logic [ADDR_W-1:0] reg_addr(input logic [CTX_W-1:0] ctx,
                                                 input logic [REG_W-1:0] off);
    return {ctx, off};
  endfunction

  // One byte per context, 0x01 while the context is busy
  function automatic logic [DATA_W-1:0] expected_status();
    logic [DATA_W-1:0] w;
    w = '0;
    for (int c = 0; c < N_CONTEXTS; c++) begin
      if (busy_model[c]) w[8*c +: 8] = 8'h01;
    end
    return w;
  endfunction

  task automatic bus_write(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
    req   = 1'b1;
    we    = 1'b1;
    addr  = a;
    wdata = d;
    @(negedge clk);
    req = 1'b0;
    we  = 1'b0;
  endtask

  // Name and expected value stay put until the response edge has passed
  task automatic bus_read(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] exp_val,
                          input string name);
    test_name = name;
    exp_rdata = exp_val;
    req       = 1'b1;
    we        = 1'b0;
    addr      = a;
    @(negedge clk);
    req = 1'b0;
    @(negedge clk);
  endtask

  task automatic acquire(input string name);
    logic [DATA_W-1:0] exp_val;
    if (locked_model) begin
      exp_val = 32'hFFFF_FFFE;
    end else if (&busy_model) begin
      exp_val = 32'hFFFF_FFFF;
    end else begin
      exp_val      = DATA_W'(offload_model);
      locked_model = 1'b1;
      offload_model++;
    end
    bus_read(reg_addr(ptr_model, REG_ACQUIRE), exp_val, name);
  endtask

  task automatic write_params(input logic [CTX_W-1:0] ctx);
    logic [DATA_W-1:0] word;
    for (int i = 0; i < N_PARAM_REGS; i++) begin
      word = $random(seed);
      param_model[ctx][i] = word;
      bus_write(reg_addr(ctx, REG_PARAM_BASE + REG_W'(i)), word);
    end
  endtask

  task automatic trigger();
    bus_write(reg_addr(ptr_model, REG_TRIGGER), '0);
    busy_model[ptr_model] = 1'b1;
    locked_model          = 1'b0;
    ptr_model             = ptr_model + 1'b1;
  endtask

  task automatic wait_start(input string name);
    int unsigned cycles;
    cycles = 0;
    while (!start && cycles < START_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!start) abort_run({"engine start did not arrive for the ", name});
    @(negedge clk);  // Start edge passed, job is running
  endtask

  task automatic pulse_done();
    done = 1'b1;
    busy_model[exp_run_ctx] = 1'b0;
    exp_run_ctx = exp_run_ctx + 1'b1;
    if (finished_model < FINISHED_MAX) finished_model++;
    running_model++;
    @(negedge clk);
    done = 1'b0;
  endtask

  task automatic read_finished(input string name);
    bus_read(reg_addr('0, REG_FINISHED), DATA_W'(finished_model), name);
    finished_model = 0;  // Cleared by the read
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    abort_run("watchdog timeout, the test sequence did not complete");
  end

  initial begin
    seed           = 32'h8aa5;
    req            = 1'b0;
    we             = 1'b0;
    addr           = '0;
    wdata          = '0;
    done           = 1'b0;
    exp_rdata      = '0;
    test_name      = "idle";
    param_model    = '0;
    busy_model     = '0;
    locked_model   = 1'b0;
    ptr_model      = '0;
    exp_run_ctx    = '0;
    offload_model  = 0;
    finished_model = 0;
    running_model  = 0;
    @(posedge rst_n);
    @(negedge clk);

    acquire("first acquire after reset");
    acquire("second acquire before trigger");

    write_params(ptr_model);
    for (int i = 0; i < N_PARAM_REGS; i++) begin
      bus_read(reg_addr('0, REG_PARAM_BASE + REG_W'(i)), param_model[0][i],
               "parameter readback");
    end
    trigger();
    wait_start("first job");
    bus_read(reg_addr('0, REG_STATUS), expected_status(), "status with one busy context");

    acquire("acquire of second context");
    write_params(ptr_model);
    trigger();
    acquire("acquire with all contexts busy");
    bus_read(reg_addr('0, REG_STATUS), expected_status(), "status with both contexts busy");

    // Third job reuses the first context while the second one runs
    pulse_done();
    wait_start("second job");
    acquire("acquire after first done");
    write_params(ptr_model);
    trigger();
    pulse_done();
    wait_start("third job");
    pulse_done();
    read_finished("finished after three jobs");
    read_finished("finished after clear");
    bus_read(reg_addr('0, REG_STATUS), expected_status(), "status with all jobs done");

    bus_read(reg_addr(1'b1, REG_RUNNING), DATA_W'(running_model), "running job id");
    bus_read(reg_addr('0, 4'd5), 32'hDEAD_BEEF, "unused offset");
    repeat (2) @(negedge clk);
    $display("Simulation PASSED");
    $finish;
  end

endmodule

//--- tests/tb_clock_gen.sv
// Clock and reset source for the job controller testbench
// Free running clock, active low reset held for a fixed number of cycles
`timescale 1ns/1ns

module tb_clock_gen #(
  parameter int unsigned PERIOD_NS    = 40,
  parameter int unsigned RESET_CYCLES = 8
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Release on a falling edge, away from the active edge
  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

//--- job_ctrl/job_ctrl_top.sv
// Job offload controller top level
// Connects the register bus and the engine to the context sequencer,
// the job counters and the contexted register store
`timescale 1ns/1ns

module job_ctrl_top (
  input  logic                                                         clk_i,
  input  logic                                                         rst_ni,
  input  logic                                                         req_i,
  input  logic                                                         we_i,
  input  logic [job_ctrl_pkg::ADDR_W-1:0]                              addr_i,
  input  logic [job_ctrl_pkg::DATA_W-1:0]                              wdata_i,
  input  logic                                                         done_i,
  output logic [job_ctrl_pkg::DATA_W-1:0]                              rdata_o,
  output logic                                                         rvalid_o,
  output logic                                                         start_o,
  output logic [job_ctrl_pkg::CTX_W-1:0]                               run_ctx_o,
  output logic [job_ctrl_pkg::N_PARAM_REGS-1:0][job_ctrl_pkg::DATA_W-1:0] params_o
);
  import job_ctrl_pkg::*;

  logic                  grant;
  logic                  acq_hit;
  logic [DATA_W-1:0]     acq_rdata;
  logic [N_CONTEXTS-1:0] ctx_busy;
  logic                  job_done;
  logic [JOB_ID_W-1:0]   offload_id;
  logic [JOB_ID_W-1:0]   running_id;
  logic [1:0]            finished_cnt;

  context_sequencer i_sequencer (
    .clk_i, .rst_ni, .req_i, .we_i, .addr_i, .done_i,
    .offload_id_i ( offload_id ),
    .grant_o      ( grant      ),
    .acq_hit_o    ( acq_hit    ),
    .acq_rdata_o  ( acq_rdata  ),
    .ctx_busy_o   ( ctx_busy   ),
    .run_ctx_o,
    .start_o,
    .job_done_o   ( job_done   )
  );

  job_counters i_counters (
    .clk_i, .rst_ni, .req_i, .we_i, .addr_i,
    .grant_i        ( grant        ),
    .job_done_i     ( job_done     ),
    .offload_id_o   ( offload_id   ),
    .running_id_o   ( running_id   ),
    .finished_cnt_o ( finished_cnt )
  );

  context_regs i_regs (
    .clk_i, .rst_ni, .req_i, .we_i, .addr_i, .wdata_i,
    .run_ctx_i      ( run_ctx_o    ),
    .ctx_busy_i     ( ctx_busy     ),
    .running_id_i   ( running_id   ),
    .finished_cnt_i ( finished_cnt ),
    .acq_hit_i      ( acq_hit      ),
    .acq_rdata_i    ( acq_rdata    ),
    .rdata_o, .rvalid_o, .params_o
  );

endmodule

//--- job_ctrl/context_regs.sv
// Contexted register store of the job offload controller
// Holds the parameter words of every context, feeds the running context
// to the engine and returns registered read data
`timescale 1ns/1ns

module context_regs (
  input  logic                                                         clk_i,
  input  logic                                                         rst_ni,
  input  logic                                                         req_i,
  input  logic                                                         we_i,
  input  logic [job_ctrl_pkg::ADDR_W-1:0]                              addr_i,
  input  logic [job_ctrl_pkg::DATA_W-1:0]                              wdata_i,
  input  logic [job_ctrl_pkg::CTX_W-1:0]                               run_ctx_i,
  input  logic [job_ctrl_pkg::N_CONTEXTS-1:0]                          ctx_busy_i,
  input  logic [job_ctrl_pkg::JOB_ID_W-1:0]                            running_id_i,
  input  logic [1:0]                                                   finished_cnt_i,
  input  logic                                                         acq_hit_i,
  input  logic [job_ctrl_pkg::DATA_W-1:0]                              acq_rdata_i,
  output logic [job_ctrl_pkg::DATA_W-1:0]                              rdata_o,
  output logic                                                         rvalid_o,
  output logic [job_ctrl_pkg::N_PARAM_REGS-1:0][job_ctrl_pkg::DATA_W-1:0] params_o
);
  import job_ctrl_pkg::*;

  logic [N_CONTEXTS-1:0][N_PARAM_REGS-1:0][DATA_W-1:0] param_mem;

  logic [REG_W-1:0]       offset;
  logic [CTX_W-1:0]       ctx;
  logic [PARAM_IDX_W-1:0] param_idx;
  logic                   param_hit;
  logic                   rd_en;
  logic [DATA_W-1:0]      status_word;
  logic [DATA_W-1:0]      rd_word;
  logic [DATA_W-1:0]      rdata_q;

  assign offset    = addr_i[REG_W-1:0];
  assign ctx       = addr_i[ADDR_W-1:REG_W];
  assign param_idx = PARAM_IDX_W'(offset - REG_PARAM_BASE);
  assign param_hit = (offset >= REG_PARAM_BASE) && (offset < REG_PARAM_BASE + N_PARAM_REGS);
  assign rd_en     = req_i & ~we_i;

  // Parameter words, written in the addressed context window
  always_ff @(posedge clk_i) begin
    if (req_i && we_i && param_hit) begin
      param_mem[ctx][param_idx] <= wdata_i;
    end
  end

  assign params_o = param_mem[run_ctx_i];  // Stable while that job runs

  // One status byte per context, 0x01 while busy
  always_comb begin
    status_word = '0;
    for (int c = 0; c < N_CONTEXTS; c++) begin
      status_word[8*c +: 8] = {7'b0, ctx_busy_i[c]};
    end
  end

  always_comb begin
    rd_word = RDATA_UNKNOWN;
    case (offset)
      REG_STATUS:   rd_word = status_word;
      REG_RUNNING:  rd_word = DATA_W'(running_id_i);
      REG_FINISHED: rd_word = DATA_W'(finished_cnt_i);
      default: begin
        if (param_hit) rd_word = param_mem[ctx][param_idx];
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= rd_en;  // Fixed one-cycle read latency
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_en) rdata_q <= rd_word;
  end

  // Acquire answer overrides the register read
  assign rdata_o = acq_hit_i ? acq_rdata_i : rdata_q;

endmodule

//--- job_ctrl/job_counters.sv
// Job id and completion counters
// Offload id counts grants, running id follows finished jobs,
// finished count saturates and clears on a bus read
`timescale 1ns/1ns

module job_counters (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              grant_i,
  input  logic                              job_done_i,
  input  logic                              req_i,
  input  logic                              we_i,
  input  logic [job_ctrl_pkg::ADDR_W-1:0]   addr_i,
  output logic [job_ctrl_pkg::JOB_ID_W-1:0] offload_id_o,
  output logic [job_ctrl_pkg::JOB_ID_W-1:0] running_id_o,
  output logic [1:0]                        finished_cnt_o
);
  import job_ctrl_pkg::*;

  logic done_q;  // Delays running id by one cycle
  logic fin_rd;

  assign fin_rd = req_i & ~we_i & (addr_i[REG_W-1:0] == REG_FINISHED);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      offload_id_o <= '0;
      running_id_o <= '0;
      done_q       <= 1'b0;
    end else begin
      done_q <= job_done_i;
      if (grant_i) offload_id_o <= offload_id_o + 1'b1;
      if (done_q)  running_id_o <= running_id_o + 1'b1;
    end
  end

  // Read clear wins over a done in the same cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      finished_cnt_o <= '0;
    end else if (fin_rd) begin
      finished_cnt_o <= '0;
    end else if (job_done_i && finished_cnt_o < FINISHED_MAX) begin
      finished_cnt_o <= finished_cnt_o + 1'b1;
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni) finished_cnt_o <= FINISHED_MAX)
    else $error("finished count above saturation value");

endmodule

//--- job_ctrl/context_sequencer.sv
// Context sequencer for the job offload controller
// Handles the ACQUIRE test-and-set, TRIGGER, the in-order context queue
// and the engine start/done handshake
`timescale 1ns/1ns

module context_sequencer (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                req_i,
  input  logic                                we_i,
  input  logic [job_ctrl_pkg::ADDR_W-1:0]     addr_i,
  input  logic                                done_i,
  input  logic [job_ctrl_pkg::JOB_ID_W-1:0]   offload_id_i,
  output logic                                grant_o,
  output logic                                acq_hit_o,
  output logic [job_ctrl_pkg::DATA_W-1:0]     acq_rdata_o,
  output logic [job_ctrl_pkg::N_CONTEXTS-1:0] ctx_busy_o,
  output logic [job_ctrl_pkg::CTX_W-1:0]      run_ctx_o,
  output logic                                start_o,
  output logic                                job_done_o
);
  import job_ctrl_pkg::*;

  seq_state_e            state_q;
  logic [CTX_W-1:0]      ptr_q;      // Next context to hand out
  logic [CTX_W-1:0]      run_ctx_q;  // Oldest queued context
  logic                  running_q;
  logic [N_CONTEXTS-1:0] busy_q;
  logic                  acq_rd, trig_wr, all_busy, acq_ok;

  assign acq_rd   = req_i & ~we_i & (addr_i[REG_W-1:0] == REG_ACQUIRE);
  assign trig_wr  = req_i & we_i & (addr_i[REG_W-1:0] == REG_TRIGGER) & (state_q == SEQ_LOCKED);
  assign all_busy = &busy_q;
  assign acq_ok   = acq_rd & (state_q == SEQ_FREE) & ~all_busy;

  assign start_o    = ~running_q & busy_q[run_ctx_q];  // Engine idle, head of queue ready
  assign job_done_o = done_i & running_q;
  assign ctx_busy_o = busy_q;
  assign run_ctx_o  = run_ctx_q;

  // Offload lock and context pointer, wraps with power-of-two context count
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= SEQ_FREE;
      ptr_q   <= '0;
    end else if (acq_ok) begin
      state_q <= SEQ_LOCKED;
    end else if (trig_wr) begin
      state_q <= SEQ_FREE;
      ptr_q   <= ptr_q + 1'b1;
    end
  end

  // Per-context busy bits
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= '0;
    end else begin
      if (trig_wr) busy_q[ptr_q] <= 1'b1;
      if (job_done_o) busy_q[run_ctx_q] <= 1'b0;
    end
  end

  // Engine runs one job at a time, in trigger order
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      running_q <= 1'b0;
      run_ctx_q <= '0;
    end else if (start_o) begin
      running_q <= 1'b1;
    end else if (job_done_o) begin
      running_q <= 1'b0;
      run_ctx_q <= run_ctx_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      grant_o   <= 1'b0;
      acq_hit_o <= 1'b0;
    end else begin
      grant_o   <= acq_ok;
      acq_hit_o <= acq_rd;
    end
  end

  // Acquire answer, lock has priority over a full queue
  always_ff @(posedge clk_i) begin
    if (acq_rd) begin
      if (state_q == SEQ_LOCKED) acq_rdata_o <= RESP_ANOTHER_OFFLOADING;
      else if (all_busy)         acq_rdata_o <= RESP_ALL_BUSY;
      else                       acq_rdata_o <= DATA_W'(offload_id_i);
    end
  end

  // After a start no second start may come before the job is done
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    start_o |=> (!start_o until job_done_o))
    else $error("engine started twice without done");

  assert property (@(posedge clk_i) disable iff (!rst_ni) grant_o |-> !all_busy)
    else $error("grant issued with all contexts busy");

endmodule

//--- common/job_ctrl_pkg.sv
// Job offload controller shared definitions
// Register map, bus widths, acquire response codes and sequencer states
package job_ctrl_pkg;

  // Bus and context geometry
  localparam int unsigned DATA_W       = 32;
  localparam int unsigned N_CONTEXTS   = 2;
  localparam int unsigned CTX_W        = 1;
  localparam int unsigned REG_W        = 4;  // Offset inside one context window
  localparam int unsigned ADDR_W       = REG_W + CTX_W;  // Context field on top
  localparam int unsigned N_PARAM_REGS = 4;
  localparam int unsigned PARAM_IDX_W  = 2;  // Index into the parameter words
  localparam int unsigned JOB_ID_W     = 8;

  // Register offsets within a context window
  localparam logic [REG_W-1:0] REG_TRIGGER    = 4'd0;  // Write to launch
  localparam logic [REG_W-1:0] REG_ACQUIRE    = 4'd1;  // Read to claim a context
  localparam logic [REG_W-1:0] REG_FINISHED   = 4'd2;  // Read and clear
  localparam logic [REG_W-1:0] REG_STATUS     = 4'd3;  // One byte per context
  localparam logic [REG_W-1:0] REG_RUNNING    = 4'd4;
  localparam logic [REG_W-1:0] REG_PARAM_BASE = 4'd8;

  // Acquire responses
  localparam logic [DATA_W-1:0] RESP_ANOTHER_OFFLOADING = 32'hFFFF_FFFE;  // -2
  localparam logic [DATA_W-1:0] RESP_ALL_BUSY           = 32'hFFFF_FFFF;  // -1

  // Answer for offsets that map to nothing
  localparam logic [DATA_W-1:0] RDATA_UNKNOWN = 32'hDEAD_BEEF;

  // Finished job counter saturates here
  localparam logic [1:0] FINISHED_MAX = 2'd2;

  // Offload lock of the sequencer
  typedef enum logic [1:0] {
    SEQ_FREE   = 2'd0,  // No master holds a context
    SEQ_LOCKED = 2'd1   // Context granted, waiting for TRIGGER
  } seq_state_e;

endpackage
